/* logic/mgr_csr_bank.sv */
`timescale 1ns/1ps

module mgr_csr_bank
(
    input  logic                    clk,
    input  logic                    reset,
    mmio_req_if.dst                 req,
    output logic                    rsp_valid,
    output vai_pkg::mmio_tid_t      rsp_tid,
    output vai_pkg::mmio_data_t     rsp_data,
    output vai_pkg::mem_addr_t      offsets [vai_pkg::NUM_SUB_AFUS],
    output vai_pkg::mmio_data_t     sub_reset
);

    vai_pkg::mmio_data_t    rd_value;   // Read data for the current request

    // Value stage
    logic                   val_valid;
    vai_pkg::mmio_tid_t     val_tid;
    vai_pkg::mmio_data_t    val_data;

    // Register writes; read-only and unmapped addresses fall through
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < vai_pkg::NUM_SUB_AFUS; i++)
            begin
                offsets[i] <= '0;
            end
            sub_reset <= '0;
        end
        else if (req.wr)
        begin
            if (req.sel_offset)
            begin
                offsets[req.vmid] <= req.data;
            end

            if (req.sel_reset)
            begin
                sub_reset <= req.data;
            end
        end
    end

    // Select the read value from the decoded selects
    always_comb
    begin
        if (req.sel_dfh)
        begin
            rd_value = vai_pkg::DFH_VALUE;
        end
        else if (req.sel_id_lo)
        begin
            rd_value = vai_pkg::MGR_ID[63:0];
        end
        else if (req.sel_id_hi)
        begin
            rd_value = vai_pkg::MGR_ID[127:64];
        end
        else if (req.sel_reset)
        begin
            rd_value = sub_reset;
        end
        else if (req.sel_nafus)
        begin
            rd_value = vai_pkg::NAFUS_VALUE;
        end
        else if (req.sel_offset)
        begin
            rd_value = offsets[req.vmid];
        end
        else
        begin
            rd_value = vai_pkg::UNMAPPED_DATA;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            val_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            val_valid <= req.rd;
            rsp_valid <= val_valid;    // Fixed latency, no back-pressure
        end
    end

    always_ff @(posedge clk)
    begin
        val_tid  <= req.tid;
        val_data <= rd_value;
        rsp_tid  <= val_tid;
        rsp_data <= val_data;
    end

endmodule

/* logic/mmio_decode.sv */
`timescale 1ns/1ps

module mmio_decode
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_valid,
    input  logic                    wr_valid,
    input  vai_pkg::mmio_addr_t     addr,
    input  vai_pkg::mmio_tid_t      tid,
    input  vai_pkg::mmio_data_t     wdata,
    mmio_req_if.src                 req
);

    // Capture stage
    logic                   s1_rd;
    logic                   s1_wr;
    vai_pkg::mmio_addr_t    s1_addr;
    vai_pkg::mmio_tid_t     s1_tid;
    vai_pkg::mmio_data_t    s1_data;

    vai_pkg::mmio_addr_t    offset_word;    // Address relative to the first offset register
    logic                   in_offset;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_rd <= 1'b0;
            s1_wr <= 1'b0;
        end
        else
        begin
            s1_rd <= rd_valid;
            s1_wr <= wr_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_addr <= addr;
        s1_tid  <= tid;
        s1_data <= wdata;
    end

    // Bit 0 of the word address is ignored inside the offset range
    assign offset_word = s1_addr - vai_pkg::ADDR_OFFSET_BASE;
    assign in_offset   = (s1_addr >= vai_pkg::ADDR_OFFSET_BASE) &&
                         (s1_addr <= vai_pkg::ADDR_OFFSET_LAST);

    // Decode stage, drives the bank directly from these flops
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req.rd         <= 1'b0;
            req.wr         <= 1'b0;
            req.sel_dfh    <= 1'b0;
            req.sel_id_lo  <= 1'b0;
            req.sel_id_hi  <= 1'b0;
            req.sel_reset  <= 1'b0;
            req.sel_nafus  <= 1'b0;
            req.sel_offset <= 1'b0;
        end
        else
        begin
            req.rd         <= s1_rd;
            req.wr         <= s1_wr;
            req.sel_dfh    <= (s1_addr == vai_pkg::ADDR_DFH);
            req.sel_id_lo  <= (s1_addr == vai_pkg::ADDR_ID_LO);
            req.sel_id_hi  <= (s1_addr == vai_pkg::ADDR_ID_HI);
            req.sel_reset  <= (s1_addr == vai_pkg::ADDR_RESET);
            req.sel_nafus  <= (s1_addr == vai_pkg::ADDR_NAFUS);
            req.sel_offset <= in_offset;
        end
    end

    always_ff @(posedge clk)
    begin
        req.tid  <= s1_tid;
        req.data <= s1_data;
        req.vmid <= offset_word[vai_pkg::VMID_W:1];    // addr/2 - 6
    end

endmodule

/* logic/mmio_req_if.sv */
`timescale 1ns/1ps

interface mmio_req_if;

    logic                   rd;         // One-cycle read pulse
    logic                   wr;         // One-cycle write pulse
    vai_pkg::mmio_tid_t     tid;
    vai_pkg::mmio_data_t    data;       // Write data
    logic                   sel_dfh;
    logic                   sel_id_lo;
    logic                   sel_id_hi;
    logic                   sel_reset;
    logic                   sel_nafus;
    logic                   sel_offset;
    vai_pkg::vmid_t         vmid;       // Valid with sel_offset

    // Decoder side
    modport src (
        output rd, wr, tid, data,
        output sel_dfh, sel_id_lo, sel_id_hi, sel_reset, sel_nafus, sel_offset,
        output vmid
    );

    // Register bank side
    modport dst (
        input rd, wr, tid, data,
        input sel_dfh, sel_id_lo, sel_id_hi, sel_reset, sel_nafus, sel_offset,
        input vmid
    );

endinterface

/* logic/vai_mgr_top.sv */
`timescale 1ns/1ps

module vai_mgr_top
(
    input  logic                    clk,
    input  logic                    reset,

    // Host MMIO request and read response
    input  logic                    mmio_rd_valid,
    input  logic                    mmio_wr_valid,
    input  vai_pkg::mmio_addr_t     mmio_addr,
    input  vai_pkg::mmio_tid_t      mmio_tid,
    input  vai_pkg::mmio_data_t     mmio_wdata,
    output logic                    rsp_valid,
    output vai_pkg::mmio_tid_t      rsp_tid,
    output vai_pkg::mmio_data_t     rsp_data,
    output vai_pkg::mmio_data_t     sub_afu_reset,

    // Sub-unit memory request
    input  logic                    mem_req,
    input  vai_pkg::vmid_t          mem_vmid,
    input  vai_pkg::mem_addr_t      mem_addr,
    output logic                    mem_ack,
    output logic                    mem_err,

    // Host memory port
    output logic                    out_req,
    output vai_pkg::mem_addr_t      out_addr,
    input  logic                    out_ack
);

    vai_pkg::mem_addr_t offsets [vai_pkg::NUM_SUB_AFUS];   // Per-vmid relocation

    mmio_req_if req_bus ();

    mmio_decode u_decode
    (
        .clk        (clk),
        .reset      (reset),
        .rd_valid   (mmio_rd_valid),
        .wr_valid   (mmio_wr_valid),
        .addr       (mmio_addr),
        .tid        (mmio_tid),
        .wdata      (mmio_wdata),
        .req        (req_bus.src)
    );

    mgr_csr_bank u_csr
    (
        .clk        (clk),
        .reset      (reset),
        .req        (req_bus.dst),
        .rsp_valid  (rsp_valid),
        .rsp_tid    (rsp_tid),
        .rsp_data   (rsp_data),
        .offsets    (offsets),
        .sub_reset  (sub_afu_reset)
    );

    vmid_addr_xlate u_xlate
    (
        .clk        (clk),
        .reset      (reset),
        .offsets    (offsets),
        .sub_reset  (sub_afu_reset),
        .mem_req    (mem_req),
        .mem_vmid   (mem_vmid),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_err    (mem_err),
        .out_req    (out_req),
        .out_addr   (out_addr),
        .out_ack    (out_ack)
    );

endmodule

/* logic/vai_pkg.sv */
package vai_pkg;

    // Sizes of the host link and the sub-unit array
    localparam int NUM_SUB_AFUS = 8;
    localparam int VMID_W       = $clog2(NUM_SUB_AFUS);
    localparam int MMIO_ADDR_W  = 16;
    localparam int MMIO_TID_W   = 9;
    localparam int DATA_W       = 64;
    localparam int MEM_ADDR_W   = 64;

    typedef logic [VMID_W-1:0]      vmid_t;         // Sub-unit number
    typedef logic [MMIO_ADDR_W-1:0] mmio_addr_t;    // MMIO word address
    typedef logic [MMIO_TID_W-1:0]  mmio_tid_t;     // Read tag, echoed back
    typedef logic [DATA_W-1:0]      mmio_data_t;    // Register word
    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;     // Host memory address

    // Register map, in 32-bit word units so 64-bit registers sit on even addresses
    localparam mmio_addr_t ADDR_DFH         = 16'd0;
    localparam mmio_addr_t ADDR_ID_LO       = 16'd2;
    localparam mmio_addr_t ADDR_ID_HI       = 16'd4;
    localparam mmio_addr_t ADDR_RESET       = 16'd6;
    localparam mmio_addr_t ADDR_NAFUS       = 16'd8;
    localparam mmio_addr_t ADDR_OFFSET_BASE = 16'd12;
    localparam mmio_addr_t ADDR_OFFSET_LAST =
        mmio_addr_t'(ADDR_OFFSET_BASE + 2 * NUM_SUB_AFUS - 1);  // 27

    // Feature header: type 1 in 63:60, end-of-list flag in bit 40
    localparam mmio_data_t DFH_VALUE = 64'h1000_0100_0000_0000;

    localparam logic [127:0] MGR_ID = 128'h5a17c3e0_9b24_4f81_b6d2_0c7e35a19f48;

    localparam mmio_data_t NAFUS_VALUE   = mmio_data_t'(NUM_SUB_AFUS);
    localparam mmio_data_t UNMAPPED_DATA = {DATA_W{1'b1}};

    // Relocation FSM
    typedef enum logic [1:0]
    {
        IDLE,       // Waiting for a new request
        FWD,        // out_req high, waiting for out_ack
        DONE,       // mem_ack high, waiting for both reqs to drop
        REFUSE      // mem_ack and mem_err high, nothing forwarded
    } xlate_state_t;

endpackage

/* logic/vmid_addr_xlate.sv */
`timescale 1ns/1ps

module vmid_addr_xlate
(
    input  logic                    clk,
    input  logic                    reset,
    input  vai_pkg::mem_addr_t      offsets [vai_pkg::NUM_SUB_AFUS],
    input  vai_pkg::mmio_data_t     sub_reset,
    input  logic                    mem_req,
    input  vai_pkg::vmid_t          mem_vmid,
    input  vai_pkg::mem_addr_t      mem_addr,
    output logic                    mem_ack,
    output logic                    mem_err,
    output logic                    out_req,
    output vai_pkg::mem_addr_t      out_addr,
    input  logic                    out_ack
);

    vai_pkg::xlate_state_t  state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= vai_pkg::IDLE;
            mem_ack <= 1'b0;
            mem_err <= 1'b0;
            out_req <= 1'b0;
        end
        else
        begin
            case (state)
                vai_pkg::IDLE:
                begin
                    if (mem_req)
                    begin
                        if (sub_reset[mem_vmid])
                        begin
                            state   <= vai_pkg::REFUSE;     // Sub-unit held in reset
                            mem_ack <= 1'b1;
                            mem_err <= 1'b1;
                        end
                        else
                        begin
                            state   <= vai_pkg::FWD;
                            out_req <= 1'b1;
                        end
                    end
                end

                vai_pkg::FWD:
                begin
                    if (out_ack)
                    begin
                        state   <= vai_pkg::DONE;
                        out_req <= 1'b0;
                        mem_ack <= 1'b1;
                        mem_err <= 1'b0;
                    end
                end

                // Both sides must finish their four-phase sequence
                vai_pkg::DONE, vai_pkg::REFUSE:
                begin
                    if (!mem_req && !out_ack)
                    begin
                        state   <= vai_pkg::IDLE;
                        mem_ack <= 1'b0;
                        mem_err <= 1'b0;
                    end
                end

                default:
                begin
                    state <= vai_pkg::IDLE;
                end
            endcase
        end
    end

    // Offset taken at capture, later writes do not reach a request in flight
    always_ff @(posedge clk)
    begin
        if (state == vai_pkg::IDLE && mem_req)
        begin
            out_addr <= mem_addr + offsets[mem_vmid];  // Wraps modulo 2^64
        end
    end

endmodule

/* test/vai_mgr_asserts.sv */
`timescale 1ns/1ps

module vai_mgr_asserts
(
    input logic clk,
    input logic reset,
    input logic mmio_rd_valid,
    input logic rsp_valid,
    input logic mem_ack,
    input logic mem_err,
    input logic out_req,
    input logic out_ack
);

    int fail_count = 0;     // Failed assertions so far

    // Responses in two adjacent cycles come from reads in two adjacent cycles
    property rsp_pair_from_b2b_reads;
        @(posedge clk) disable iff (reset)
            rsp_valid && $past(rsp_valid) |-> $past(mmio_rd_valid, 4) && $past(mmio_rd_valid, 5);
    endproperty
    a_rsp_pair: assert property (rsp_pair_from_b2b_reads)
    else
    begin
        fail_count++;
        $error("rsp_valid high in two cycles without back-to-back reads");
    end

    property ack_not_with_out_req;
        @(posedge clk) disable iff (reset) $rose(mem_ack) |-> !out_req;
    endproperty
    a_ack_out_req: assert property (ack_not_with_out_req)
    else
    begin
        fail_count++;
        $error("mem_ack rose while out_req was high");
    end

    // Host side of the four-phase handshake
    property out_req_held_until_ack;
        @(posedge clk) disable iff (reset) $fell(out_req) |-> $past(out_ack);
    endproperty
    a_out_req_held: assert property (out_req_held_until_ack)
    else
    begin
        fail_count++;
        $error("out_req dropped before out_ack was high");
    end

    property err_only_with_ack;
        @(posedge clk) disable iff (reset) mem_err |-> mem_ack;
    endproperty
    a_err_ack: assert property (err_only_with_ack)
    else
    begin
        fail_count++;
        $error("mem_err high while mem_ack was low");
    end

endmodule

bind vai_mgr_top vai_mgr_asserts u_asserts
(
    .clk            (clk),
    .reset          (reset),
    .mmio_rd_valid  (mmio_rd_valid),
    .rsp_valid      (rsp_valid),
    .mem_ack        (mem_ack),
    .mem_err        (mem_err),
    .out_req        (out_req),
    .out_ack        (out_ack)
);

/* test/vai_mgr_tb.sv */
`timescale 1ns/1ps

module vai_mgr_tb;

    localparam int         TIMEOUT = 50;    // Cycles allowed for any single wait
    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_XL   = 2'd2;  // Translate with the vmid in addr

    typedef struct packed
    {
        logic [1:0]  op;
        logic        no_wait;   // Next read follows in the next cycle
        logic [15:0] addr;
        logic [63:0] data;      // Write data or mem_addr of a translate
        logic [63:0] expd;      // Read data or mem_err of a translate
    } step_t;

    logic        clk;
    logic        reset;
    logic        mmio_rd_valid;
    logic        mmio_wr_valid;
    logic [15:0] mmio_addr;
    logic [8:0]  mmio_tid;
    logic [63:0] mmio_wdata;
    logic        rsp_valid;
    logic [8:0]  rsp_tid;
    logic [63:0] rsp_data;
    logic [63:0] sub_afu_reset;
    logic        mem_req;
    logic [2:0]  mem_vmid;
    logic [63:0] mem_addr;
    logic        mem_ack;
    logic        mem_err;
    logic        out_req;
    logic [63:0] out_addr;
    logic        out_ack;

    step_t       steps [$];
    logic [63:0] off_model [8];     // Offsets as written so far
    logic [63:0] reset_model;
    logic [8:0]  next_tid;
    int          cycle;
    int          seed = 42716;
    int          checks;
    int          errors;
    logic        out_seen;          // Responder saw out_req in this translate
    logic [63:0] out_seen_addr;
    logic [8:0]  exp_tid_q [$];     // Reads waiting for their response
    logic [63:0] exp_data_q [$];
    int          exp_cycle_q [$];

    vai_mgr_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // Checks each response in order for tid, data and latency
    always @(posedge clk)
    begin
        if (!reset && rsp_valid)
        begin
            if (exp_tid_q.size() == 0)
            begin
                $display("ERROR at %0t ns: read response with no read outstanding", $time);
                errors++;
            end
            else
            begin
                check_equal("rsp_tid", rsp_tid, exp_tid_q.pop_front());
                check_equal("rsp_data", rsp_data, exp_data_q.pop_front());
                check_equal("rsp_valid cycle", cycle, exp_cycle_q.pop_front() + 4);
            end
        end
    end

    // Host memory responder
    initial
    begin : responder
        int delay;
        int n;
        forever
        begin
            @(posedge clk);
            if (out_req)
            begin
                out_seen      = 1'b1;
                out_seen_addr = out_addr;
                delay         = {$random(seed)} % 4;    // 0 to 3 cycles
                repeat (delay) @(posedge clk);
                out_ack <= 1'b1;
                n = 0;
                @(posedge clk);
                while (out_req)
                begin
                    if (n == TIMEOUT)
                    begin
                        stop_on_timeout("out_req did not drop after out_ack");
                    end
                    @(posedge clk);
                    n++;
                end
                out_ack <= 1'b0;
            end
        end
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("TIMEOUT at %0t ns: %s", $time, what);
        errors++;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    function automatic logic [63:0] offset_value(input int v);
        return 64'h1111_0000_0000_1000 * (v + 1);
    endfunction

    task automatic add_step(input logic [1:0] op, input logic [15:0] addr,
                            input logic [63:0] data, input logic [63:0] expd,
                            input logic no_wait);
        steps.push_back({op, no_wait, addr, data, expd});
    endtask

    // Advances one clock and returns the MMIO strobes to idle
    task automatic next_cycle();
        @(posedge clk);
        mmio_rd_valid <= 1'b0;
        mmio_wr_valid <= 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [63:0] data);
        logic [63:0] old_reset;
        old_reset = reset_model;
        next_cycle();
        mmio_wr_valid <= 1'b1;
        mmio_addr     <= addr;
        mmio_wdata    <= data;
        if (addr >= 16'd12 && addr <= 16'd27)
        begin
            off_model[(addr - 16'd12) >> 1] = data;
        end
        if (addr == 16'd6)
        begin
            reset_model = data;
            repeat (3) next_cycle();    // Still the old word at N+2
            check_equal("sub_afu_reset at N+2", sub_afu_reset, old_reset);
            next_cycle();
            check_equal("sub_afu_reset at N+3", sub_afu_reset, data);
        end
    endtask

    task automatic issue_read(input logic [15:0] addr, input logic [63:0] expd,
                              input logic no_wait);
        int n;
        next_cycle();
        mmio_rd_valid <= 1'b1;
        mmio_addr     <= addr;
        mmio_tid      <= next_tid;
        exp_tid_q.push_back(next_tid);
        exp_data_q.push_back(expd);
        exp_cycle_q.push_back(cycle + 1);     // DUT samples it at the next edge
        next_tid = next_tid + 9'd37;
        if (!no_wait)
        begin
            n = 0;
            while (exp_tid_q.size() != 0)
            begin
                if (n == TIMEOUT)
                begin
                    stop_on_timeout("read response did not arrive");
                end
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic translate_req(input logic [2:0] vmid, input logic [63:0] addr,
                                 input logic exp_err);
        int n;
        logic [63:0] exp_addr;
        exp_addr = addr + off_model[vmid];     // Modulo 2^64
        out_seen = 1'b0;
        next_cycle();
        mem_req  <= 1'b1;
        mem_vmid <= vmid;
        mem_addr <= addr;
        n = 0;
        while (!mem_ack)
        begin
            if (n == TIMEOUT)
            begin
                stop_on_timeout("mem_ack did not rise");
            end
            @(posedge clk);
            n++;
        end
        check_equal("mem_err", mem_err, exp_err);
        check_equal("out_req seen", out_seen, !exp_err);
        if (!exp_err)
        begin
            check_equal("out_addr", out_seen_addr, exp_addr);
        end
        mem_req <= 1'b0;
        n = 0;
        while (mem_ack)
        begin
            if (n == TIMEOUT)
            begin
                stop_on_timeout("mem_ack did not drop after mem_req fell");
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic load_table();
        add_step(OP_RD, 16'd0, '0, 64'h1000_0100_0000_0000, 1'b0);   // DFH
        add_step(OP_RD, 16'd2, '0, 64'hb6d2_0c7e_35a1_9f48, 1'b0);   // ID low half
        add_step(OP_RD, 16'd4, '0, 64'h5a17_c3e0_9b24_4f81, 1'b0);
        add_step(OP_RD, 16'd8, '0, 64'd8, 1'b0);
        add_step(OP_RD, 16'd40, '0, {64{1'b1}}, 1'b0);               // Unmapped
        add_step(OP_RD, 16'd6, '0, 64'd0, 1'b0);
        for (int v = 0; v < 8; v++)
        begin
            add_step(OP_WR, 16'(12 + 2 * v), offset_value(v), '0, 1'b0);
        end
        // Reverse order with odd vmids read through the odd address of the pair
        for (int v = 7; v >= 0; v--)
        begin
            add_step(OP_RD, 16'(12 + 2 * v + v % 2), '0, offset_value(v), 1'b0);
        end
        add_step(OP_WR, 16'd0, 64'h1234_5678, '0, 1'b0);             // Read-only
        add_step(OP_RD, 16'd0, '0, 64'h1000_0100_0000_0000, 1'b0);
        add_step(OP_WR, 16'd8, 64'hff, '0, 1'b0);
        add_step(OP_RD, 16'd8, '0, 64'd8, 1'b0);
        add_step(OP_WR, 16'd6, 64'h24, '0, 1'b0);                    // vmids 2 and 5 held
        add_step(OP_RD, 16'd6, '0, 64'h24, 1'b0);
        add_step(OP_XL, 16'd0, 64'h0000_0000_0040_0000, 64'd0, 1'b0);
        add_step(OP_XL, 16'd3, 64'h0000_1234_5678_9abc, 64'd0, 1'b0);
        add_step(OP_XL, 16'd6, 64'h0000_0000_0000_0007, 64'd0, 1'b0);
        add_step(OP_XL, 16'd7, 64'hf000_0000_0000_0123, 64'd0, 1'b0);  // Sum wraps
        add_step(OP_XL, 16'd2, 64'h0000_0000_0000_5000, 64'd1, 1'b0);
        add_step(OP_XL, 16'd5, 64'h0000_0000_0000_6000, 64'd1, 1'b0);
        add_step(OP_WR, 16'd6, 64'h20, '0, 1'b0);                    // Release vmid 2
        add_step(OP_XL, 16'd2, 64'h0000_0000_0000_5000, 64'd0, 1'b0);
        add_step(OP_XL, 16'd5, 64'h0000_0000_0000_6000, 64'd1, 1'b0);
        add_step(OP_RD, 16'd26, '0, offset_value(7), 1'b1);          // Back to back
        add_step(OP_RD, 16'd0, '0, 64'h1000_0100_0000_0000, 1'b1);
        add_step(OP_RD, 16'd6, '0, 64'h20, 1'b1);
        add_step(OP_RD, 16'd12, '0, offset_value(0), 1'b0);
    endtask

    initial
    begin
        reset         = 1'b1;
        mmio_rd_valid = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_addr     = '0;
        mmio_tid      = '0;
        mmio_wdata    = '0;
        mem_req       = 1'b0;
        mem_vmid      = '0;
        mem_addr      = '0;
        out_ack       = 1'b0;
        cycle         = 0;
        checks        = 0;
        errors        = 0;
        next_tid      = 9'h0a5;
        reset_model   = '0;
        for (int v = 0; v < 8; v++)
        begin
            off_model[v] = '0;
        end
        load_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        check_equal("rsp_valid after reset", rsp_valid, 1'b0);
        check_equal("mem_ack after reset", mem_ack, 1'b0);
        check_equal("mem_err after reset", mem_err, 1'b0);
        check_equal("out_req after reset", out_req, 1'b0);
        check_equal("sub_afu_reset after reset", sub_afu_reset, '0);
        for (int i = 0; i < steps.size(); i++)
        begin
            case (steps[i].op)
                OP_WR:   write_reg(steps[i].addr, steps[i].data);
                OP_RD:   issue_read(steps[i].addr, steps[i].expd, steps[i].no_wait);
                default: translate_req(steps[i].addr[2:0], steps[i].data, steps[i].expd[0]);
            endcase
        end
        errors = errors + i_dut.u_asserts.fail_count;   // Protocol assertion failures
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vai_mgr_top.f */
logic/vai_pkg.sv
logic/mmio_req_if.sv
logic/mmio_decode.sv
logic/mgr_csr_bank.sv
logic/vmid_addr_xlate.sv
logic/vai_mgr_top.sv
test/vai_mgr_asserts.sv
test/vai_mgr_tb.sv
